// File: project.f
+incdir+source
source/dcache_pkg.sv
source/cpu_req_port.sv
source/cache_array.sv
source/cache_ctrl.sv
source/mem_port.sv
source/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// File: Makefile
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: tests/tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam logic [`DC_ADDR_W-1:0] INIT_XOR = 32'h5a3c_96e1;
    localparam int N_FIRST  = 16;
    localparam int N_RANDOM = 400;
    localparam int N_TRANS  = 4 * N_FIRST + 6 + N_RANDOM;
    localparam int TIMEOUT  = 400 * N_TRANS;
    localparam logic [`DC_INDEX_W-1:0] EVICT_SET = 7'h10;
    // cycles with req high and ack still low on a hit
    localparam int HIT_ACK_CYCLES = 4;

    logic                  clk;
    logic                  rst;
    logic                  cpu_req;
    cpu_req_t              cpu_in;
    logic                  cpu_ack;
    logic [`DC_DATA_W-1:0] cpu_rdata;
    logic                  mem_req;
    mem_cmd_t              mem_cmd;
    logic                  mem_ack;
    line_t                 mem_rdata;
    int                    wb_count;
    logic [`DC_TAG_W+`DC_INDEX_W-1:0] last_wb;

    logic [31:0]           lfsr = 32'h809a_1419;
    logic [31:0]           shadow [logic [31:0]];
    logic [31:0]           exp_q [$];
    logic                  ack_d  = 1'b0;
    int                    cycles = 0;
    int                    ack_wait = 0;

    dcache_top u_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req),
        .cpu_i       (cpu_in),
        .cpu_ack_o   (cpu_ack),
        .cpu_rdata_o (cpu_rdata),
        .mem_req_o   (mem_req),
        .mem_cmd_o   (mem_cmd),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    mem_model #(.INIT_XOR(INIT_XOR)) u_mem_model (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req),
        .mem_cmd_i   (mem_cmd),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata),
        .wb_count_o  (wb_count),
        .last_wb_o   (last_wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`DC_TAG_W-1:0] tag_of(input logic [1:0] sel);
        case (sel)
            2'd0:    return 20'h0_1234;
            2'd1:    return 20'h8_a5c1;
            default: return 20'hf_00e7;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input logic [1:0] tag_sel,
                                              input logic [`DC_INDEX_W-1:0] index,
                                              input logic [`DC_WSEL_W-1:0] wsel);
        addr_u a;
        a.f.tag   = tag_of(tag_sel);
        a.f.index = index;
        a.f.wsel  = wsel;
        a.f.boff  = '0;
        return a.raw;
    endfunction

    // three tags over four sets
    function automatic logic [31:0] pick_addr();
        logic [1:0]             tag_sel;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_WSEL_W-1:0]  wsel;
        tag_sel = 2'(rand_bits(2) % 3);
        index   = 7'h40 | 7'(rand_bits(2));
        wsel    = 3'(rand_bits(3));
        return make_addr(tag_sel, index, wsel);
    endfunction

    // expected word from the last merged write or the memory fill
    function automatic logic [31:0] expect_word(input logic wr, input logic [31:0] addr,
                                                input logic [31:0] wdata,
                                                input logic [3:0] strb);
        logic [31:0] word;
        if (shadow.exists(addr)) begin
            word = shadow[addr];
        end else begin
            word = addr ^ INIT_XOR;
        end
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow[addr] = word;
        end
        return word;
    endfunction

    task automatic run_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb);
        cpu_req_t r;
        r.write    = wr;
        r.addr.raw = addr;
        r.wdata    = wdata;
        r.strb     = strb;
        exp_q.push_back(expect_word(wr, addr, wdata, strb));
        @(posedge clk);
        cpu_in  <= r;
        cpu_req <= 1'b1;
        ack_wait = 0;
        @(posedge clk);
        while (!cpu_ack) begin
            ack_wait++;
            @(posedge clk);
        end
        cpu_req <= 1'b0;
        do @(posedge clk); while (cpu_ack);
    endtask

    ////////////////////////////////////////
    // checking and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        ack_d <= cpu_ack;
        if (rst && cpu_ack && !ack_d) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("cpu_ack_o rose with no request pending");
            end else begin
                compare_value("cpu_rdata_o", cpu_rdata, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            stop_with_failure("timeout, the cache stopped answering");
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        wr;
        int          wb_before;
        rst     = 1'b0;
        cpu_req = 1'b0;
        cpu_in  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);

        // read miss then the same word again as a hit
        for (int i = 0; i < N_FIRST; i++) begin
            addr = pick_addr();
            run_access(1'b0, addr, '0, '0);
            run_access(1'b0, addr, '0, '0);
            compare_value("cpu_ack_o latency", ack_wait, HIT_ACK_CYCLES);
        end

        // strobed write then read back
        for (int i = 0; i < N_FIRST; i++) begin
            addr  = pick_addr();
            wdata = rand_bits(32);
            strb  = 4'(rand_bits(4));
            run_access(1'b1, addr, wdata, strb);
            run_access(1'b0, addr, '0, '0);
        end

        // three tags in a fresh set evict the first one dirty
        wb_before = wb_count;
        for (int t = 0; t < 3; t++) begin
            run_access(1'b1, make_addr(2'(t), EVICT_SET, 3'd5), rand_bits(32), 4'hf);
        end
        if (wb_count == wb_before) begin
            stop_with_failure("evicting a dirty line wrote nothing back to memory");
        end
        compare_value("last_wb_o", {5'b0, last_wb}, {5'b0, tag_of(2'd0), EVICT_SET});
        for (int t = 0; t < 3; t++) begin
            run_access(1'b0, make_addr(2'(t), EVICT_SET, 3'd5), '0, '0);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            wr    = rand_bits(1) == 32'd1;
            addr  = pick_addr();
            wdata = rand_bits(32);
            strb  = 4'(rand_bits(4));
            run_access(wr, addr, wdata, strb);
        end

        repeat (4) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: tests/mem_model.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module mem_model #(
    parameter logic [`DC_ADDR_W-1:0] INIT_XOR = 32'h0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mem_req_i,
    input  dcache_pkg::mem_cmd_t                mem_cmd_i,
    output logic                                mem_ack_o,
    output dcache_pkg::line_t                   mem_rdata_o,
    output int                                  wb_count_o,
    output logic [`DC_TAG_W+`DC_INDEX_W-1:0]    last_wb_o
);
    import dcache_pkg::*;

    localparam int LA_W = `DC_TAG_W + `DC_INDEX_W;

    // lines never written come from the fill pattern
    line_t            lines [logic [LA_W-1:0]];
    logic [LA_W-1:0]  la;
    logic             ack_q   = 1'b0;
    line_t            rdata_q = '0;
    int               wb_count = 0;
    logic [LA_W-1:0]  last_wb = '0;

    function automatic line_t fill_line(input logic [LA_W-1:0] line_addr);
        line_t l;
        for (int w = 0; w < `DC_WORDS; w++) begin
            l[w] = {line_addr, w[`DC_WSEL_W-1:0], 2'b00} ^ INIT_XOR;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        la = {mem_cmd_i.tag, mem_cmd_i.index};
        if (!rst) begin
            ack_q    <= 1'b0;
            wb_count <= 0;
        end else if (mem_req_i && !ack_q) begin
            if (mem_cmd_i.write) begin
                lines[la] = mem_cmd_i.data;
                wb_count <= wb_count + 1;
                last_wb  <= la;
            end else if (lines.exists(la)) begin
                rdata_q <= lines[la];
            end else begin
                rdata_q <= fill_line(la);
            end
            ack_q <= 1'b1;
        end else if (!mem_req_i && ack_q) begin
            ack_q <= 1'b0;
        end
    end

    assign mem_ack_o   = ack_q;
    assign mem_rdata_o = rdata_q;
    assign wb_count_o  = wb_count;
    assign last_wb_o   = last_wb;

endmodule

// File: source/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_i,
    input  dcache_pkg::cpu_req_t  cpu_i,
    output logic                  cpu_ack_o,
    output logic [`DC_DATA_W-1:0] cpu_rdata_o,
    output logic                  mem_req_o,
    output dcache_pkg::mem_cmd_t  mem_cmd_o,
    input  logic                  mem_ack_i,
    input  dcache_pkg::line_t     mem_rdata_i
);
    import dcache_pkg::*;

    cpu_req_t               req;
    logic                   req_valid;
    logic                   done;
    logic [`DC_DATA_W-1:0]  rdata;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_TAG_W-1:0]   tag;
    logic                   wr_en;
    logic                   wr_way;
    line_t                  wr_line;
    logic                   wr_dirty;
    logic                   lru_upd;
    logic                   lru_way;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [`DC_TAG_W-1:0]   victim_tag;
    line_t                  hit_line;
    line_t                  victim_line;
    logic                   mem_start;
    mem_cmd_t               mem_cmd;
    logic                   mem_done;
    line_t                  mem_line;

    cpu_req_port u_cpu_req_port (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .cpu_i       (cpu_i),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .req_valid_o (req_valid),
        .req_o       (req),
        .done_i      (done),
        .rdata_i     (rdata)
    );

    cache_ctrl u_cache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .done_o         (done),
        .rdata_o        (rdata),
        .index_o        (index),
        .tag_o          (tag),
        .wr_en_o        (wr_en),
        .wr_way_o       (wr_way),
        .wr_line_o      (wr_line),
        .wr_dirty_o     (wr_dirty),
        .lru_upd_o      (lru_upd),
        .lru_way_o      (lru_way),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .hit_line_i     (hit_line),
        .victim_line_i  (victim_line),
        .mem_start_o    (mem_start),
        .mem_cmd_o      (mem_cmd),
        .mem_done_i     (mem_done),
        .mem_line_i     (mem_line)
    );

    cache_array u_cache_array (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index),
        .tag_i          (tag),
        .wr_en_i        (wr_en),
        .wr_way_i       (wr_way),
        .wr_line_i      (wr_line),
        .wr_dirty_i     (wr_dirty),
        .lru_upd_i      (lru_upd),
        .lru_way_i      (lru_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .hit_line_o     (hit_line),
        .victim_line_o  (victim_line)
    );

    mem_port u_mem_port (
        .clk         (clk),
        .rst         (rst),
        .start_i     (mem_start),
        .cmd_i       (mem_cmd),
        .done_o      (mem_done),
        .line_o      (mem_line),
        .mem_req_o   (mem_req_o),
        .mem_cmd_o   (mem_cmd_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// File: source/mem_port.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module mem_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  dcache_pkg::mem_cmd_t cmd_i,
    output logic                 done_o,
    output dcache_pkg::line_t    line_o,
    output logic                 mem_req_o,
    output dcache_pkg::mem_cmd_t mem_cmd_o,
    input  logic                 mem_ack_i,
    input  dcache_pkg::line_t    mem_rdata_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DROP
    } state_t;

    state_t   state;
    mem_cmd_t cmd_q;
    line_t    line_q;

    // req up then ack up then req down then ack down
    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= ST_IDLE;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack_i) begin
                        state <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (!mem_ack_i) begin
                        done_o <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            cmd_q <= cmd_i;
        end
        // read data only valid while ack is high
        if (state == ST_REQ && mem_ack_i && !cmd_q.write) begin
            line_q <= mem_rdata_i;
        end
    end

    assign mem_req_o = (state == ST_REQ);
    assign mem_cmd_o = cmd_q;
    assign line_o    = line_q;

    cmd_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_cmd_o));

endmodule

// File: source/cache_ctrl.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module cache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  dcache_pkg::cpu_req_t   req_i,
    output logic                   done_o,
    output logic [`DC_DATA_W-1:0]  rdata_o,
    output logic [`DC_INDEX_W-1:0] index_o,
    output logic [`DC_TAG_W-1:0]   tag_o,
    output logic                   wr_en_o,
    output logic                   wr_way_o,
    output dcache_pkg::line_t      wr_line_o,
    output logic                   wr_dirty_o,
    output logic                   lru_upd_o,
    output logic                   lru_way_o,
    input  logic                   hit_i,
    input  logic                   hit_way_i,
    input  logic                   victim_way_i,
    input  logic                   victim_dirty_i,
    input  logic [`DC_TAG_W-1:0]   victim_tag_i,
    input  dcache_pkg::line_t      hit_line_i,
    input  dcache_pkg::line_t      victim_line_i,
    output logic                   mem_start_o,
    output dcache_pkg::mem_cmd_t   mem_cmd_o,
    input  logic                   mem_done_i,
    input  dcache_pkg::line_t      mem_line_i
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FINISH
    } state_t;

    state_t                state;
    logic                  way_q;
    logic                  miss_q;
    line_t                 base_line;
    line_t                 merged_line;
    logic [`DC_WSEL_W-1:0] wsel;

    assign wsel    = req_i.addr.f.wsel;
    assign index_o = req_i.addr.f.index;
    assign tag_o   = req_i.addr.f.tag;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= ST_IDLE;
            mem_start_o <= 1'b0;
            miss_q      <= 1'b0;
        end else begin
            mem_start_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    miss_q <= !hit_i;
                    if (hit_i) begin
                        state <= ST_FINISH;
                    end else begin
                        mem_start_o <= 1'b1;
                        state       <= victim_dirty_i ? ST_WRITEBACK : ST_REFILL;
                    end
                end
                ST_WRITEBACK: begin
                    // victim is out, now fetch the new line
                    if (mem_done_i) begin
                        mem_start_o <= 1'b1;
                        state       <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (mem_done_i) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // target way and memory command
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            way_q           <= hit_i ? hit_way_i : victim_way_i;
            mem_cmd_o.write <= victim_dirty_i;
            mem_cmd_o.tag   <= victim_dirty_i ? victim_tag_i : tag_o;
            mem_cmd_o.index <= index_o;
            mem_cmd_o.data  <= victim_line_i;
        end else if (state == ST_WRITEBACK && mem_done_i) begin
            mem_cmd_o.write <= 1'b0;
            mem_cmd_o.tag   <= tag_o;
        end
    end

    ////////////////////////////////////////
    // byte merge
    ////////////////////////////////////////

    always_comb begin
        // refilled line on a miss, else the hit way
        base_line   = miss_q ? mem_line_i : hit_line_i;
        merged_line = base_line;
        if (req_i.write) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (req_i.strb[b]) begin
                    merged_line[wsel][8*b +: 8] = req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign done_o     = (state == ST_FINISH);
    assign rdata_o    = merged_line[wsel];
    assign wr_en_o    = (state == ST_FINISH) && (miss_q || req_i.write);
    assign wr_way_o   = way_q;
    assign wr_line_o  = merged_line;
    assign wr_dirty_o = req_i.write;
    assign lru_upd_o  = (state == ST_FINISH);
    assign lru_way_o  = way_q;

endmodule

// File: source/cache_array.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module cache_array (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_TAG_W-1:0]   tag_i,
    input  logic                   wr_en_i,
    input  logic                   wr_way_i,
    input  dcache_pkg::line_t      wr_line_i,
    input  logic                   wr_dirty_i,
    input  logic                   lru_upd_i,
    input  logic                   lru_way_i,
    output logic                   hit_o,
    output logic                   hit_way_o,
    output logic                   victim_way_o,
    output logic                   victim_dirty_o,
    output logic [`DC_TAG_W-1:0]   victim_tag_o,
    output dcache_pkg::line_t      hit_line_o,
    output dcache_pkg::line_t      victim_line_o
);
    import dcache_pkg::*;

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [`DC_TAG_W-1:0]  tag_mem  [2][SETS];
    logic [`DC_LINE_W-1:0] data_mem [2][SETS];
    logic [1:0][SETS-1:0]  valid_r;
    logic [1:0][SETS-1:0]  dirty_r;
    // way used last, per set
    logic [SETS-1:0]       mru_r;

    addr_fields_t          look_q;
    logic [`DC_TAG_W-1:0]  tag_q  [2];
    line_t                 line_q [2];
    logic [1:0]            way_hit;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][index_i]  <= tag_i;
            data_mem[wr_way_i][index_i] <= wr_line_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_r <= '0;
            dirty_r <= '0;
            mru_r   <= '0;
        end else begin
            if (wr_en_i) begin
                valid_r[wr_way_i][index_i] <= 1'b1;
                dirty_r[wr_way_i][index_i] <= wr_dirty_i;
            end
            if (lru_upd_i) begin
                mru_r[index_i] <= lru_way_i;
            end
        end
    end

    // read port, one cycle behind index_i
    always_ff @(posedge clk) begin
        look_q.tag   <= tag_i;
        look_q.index <= index_i;
        look_q.wsel  <= '0;
        look_q.boff  <= '0;
        for (int w = 0; w < 2; w++) begin
            tag_q[w]  <= tag_mem[w][index_i];
            line_q[w] <= data_mem[w][index_i];
        end
    end

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_r[w][look_q.index] && (tag_q[w] == look_q.tag);
        end
    end

    assign hit_o        = |way_hit;
    assign hit_way_o    = way_hit[1];
    assign hit_line_o   = line_q[way_hit[1]];

    // evict whichever way was not touched last
    assign victim_way_o   = ~mru_r[look_q.index];
    assign victim_dirty_o = valid_r[victim_way_o][look_q.index]
                            && dirty_r[victim_way_o][look_q.index];
    assign victim_tag_o   = tag_q[victim_way_o];
    assign victim_line_o  = line_q[victim_way_o];

    one_way_hit: assert property (@(posedge clk) disable iff (!rst)
        !(&way_hit));

endmodule

// File: source/cpu_req_port.sv
`timescale 1ns/10ps
`include "dcache_defines.svh"

module cpu_req_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_i,
    input  dcache_pkg::cpu_req_t  cpu_i,
    output logic                  cpu_ack_o,
    output logic [`DC_DATA_W-1:0] cpu_rdata_o,
    output logic                  req_valid_o,
    output dcache_pkg::cpu_req_t  req_o,
    input  logic                  done_i,
    input  logic [`DC_DATA_W-1:0] rdata_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK
    } state_t;

    state_t                state;
    cpu_req_t              req_q;
    logic [`DC_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= ST_IDLE;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cpu_req_i) begin
                        req_valid_o <= 1'b1;
                        state       <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (done_i) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // hold ack until the cpu lets go
                    if (!cpu_req_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cpu_req_i) begin
            req_q <= cpu_i;
        end
        if (state == ST_BUSY && done_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign req_o       = req_q;
    assign cpu_ack_o   = (state == ST_ACK);
    assign cpu_rdata_o = rdata_q;

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack_o) |-> cpu_req_i);

endmodule

// File: source/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_WSEL_W-1:0]  wsel;
        logic [`DC_BYTE_W-1:0]  boff;
    } addr_fields_t;

    // one address word, seen raw or split into fields
    typedef union packed {
        logic [`DC_ADDR_W-1:0] raw;
        addr_fields_t          f;
    } addr_u;

    typedef struct packed {
        logic                  write;
        addr_u                 addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic [`DC_STRB_W-1:0] strb;
    } cpu_req_t;

    // word 0 in the low bits
    typedef logic [`DC_WORDS-1:0][`DC_DATA_W-1:0] line_t;

    // whole line transfer, line address only
    typedef struct packed {
        logic                   write;
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        line_t                  data;
    } mem_cmd_t;

endpackage

// File: source/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

////////////////////////////////////////
// address split
////////////////////////////////////////

// tag | index | word select | byte offset
`define DC_ADDR_W  32
`define DC_DATA_W  32
`define DC_TAG_W   20
`define DC_INDEX_W 7
`define DC_WSEL_W  3
`define DC_BYTE_W  2

////////////////////////////////////////
// line geometry
////////////////////////////////////////

`define DC_WORDS   8
`define DC_LINE_W  256
`define DC_STRB_W  4

`endif
